// File: hdl/satd_pkg.sv
/*
 * Datapath widths and types of the 4x4 SATD engine.
 * Imported by the transform stages, the drain and the top level.
 */
`default_nettype none

package satd_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int pixel_w = 8;
    // pixels per row, also the number of column units
    localparam int lanes = 4;
    // l0 - l1 spans -255 .. 255
    localparam int resid_w = 9;
    // four residuals summed
    localparam int row_coef_w = 11;
    // four row coefficients summed
    localparam int col_coef_w = 13;
    // sixteen magnitudes, at most 16320
    localparam int satd_w = 17;

    // ==================================================
    // types
    // ==================================================
    typedef logic [pixel_w-1:0] pixel_t;
    typedef logic signed [row_coef_w-1:0] row_coef_t;
    typedef logic signed [col_coef_w-1:0] col_coef_t;
    typedef logic [satd_w-1:0] satd_t;

endpackage

`default_nettype wire

// File: hdl/search_pkg.sv
/*
 * Search window definitions: how many candidates a search visits
 * and the width of the index that names the winner.
 */
`default_nettype none

package search_pkg;

    // 3x3 search around the start point
    localparam int num_candidates_default = 9;

    // wide enough for up to 16 candidates
    localparam int cand_idx_w = 4;

    // candidate number inside one search, 0 first
    typedef logic [cand_idx_w-1:0] cand_idx_t;

endpackage

`default_nettype wire

// File: hdl/row_transform.sv
/*
 * Row stage: L0 - L1 residual per lane and the horizontal 4-point
 * Hadamard butterfly, held in one valid/ready output register.
 */
`timescale 1ns/1ps
`default_nettype none

module row_transform (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      in_valid,
    output logic                                      in_ready,
    input  satd_pkg::pixel_t  [satd_pkg::lanes-1:0]   in_l0,
    input  satd_pkg::pixel_t  [satd_pkg::lanes-1:0]   in_l1,
    output logic                                      row_valid,
    input  logic                                      row_ready,
    output satd_pkg::row_coef_t [satd_pkg::lanes-1:0] row_coef
);
    import satd_pkg::*;

    logic signed [resid_w-1:0] resid [lanes];
    row_coef_t [lanes-1:0]     coef_next;
    logic                      in_fire;

    // ==================================================
    // residual and butterfly
    // ==================================================
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            resid[i] = $signed({1'b0, in_l0[i]}) - $signed({1'b0, in_l1[i]});
        end
    end

    always_comb begin
        row_coef_t r0;
        row_coef_t r1;
        row_coef_t r2;
        row_coef_t r3;
        // sign extend before the adds
        r0 = resid[0];
        r1 = resid[1];
        r2 = resid[2];
        r3 = resid[3];
        coef_next[0] = r0 + r1 + r2 + r3;
        coef_next[1] = r0 - r1 + r2 - r3;
        coef_next[2] = r0 + r1 - r2 - r3;
        coef_next[3] = r0 - r1 - r2 + r3;
    end

    // ==================================================
    // output register
    // ==================================================
    assign in_ready = !row_valid || row_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_valid <= 1'b0;
        end else if (in_fire) begin
            row_valid <= 1'b1;
        end else if (row_ready) begin
            row_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            row_coef <= coef_next;
        end
    end

    // stalled row must reach the column units unchanged
    assert property (@(posedge clk) disable iff (!rst_n)
        row_valid && !row_ready |=> row_valid && $stable(row_coef));

endmodule

`default_nettype wire

// File: hdl/column_accum.sv
/*
 * One column of the vertical Hadamard butterfly. Folds four row
 * coefficients into four block coefficients, then holds the block.
 */
`timescale 1ns/1ps
`default_nettype none

module column_accum (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      row_valid,
    output logic                                      row_ready,
    input  satd_pkg::row_coef_t                       coef_in,
    output logic                                      blk_valid,
    input  logic                                      blk_ready,
    output satd_pkg::col_coef_t [satd_pkg::lanes-1:0] col_coef
);
    import satd_pkg::*;

    // row number inside the current block
    logic [1:0] row_cnt;
    logic       row_fire;
    col_coef_t  coef_ext;
    col_coef_t  acc [lanes];

    assign row_ready = !blk_valid || blk_ready;
    assign row_fire  = row_valid && row_ready;
    assign coef_ext  = coef_in;

    always_comb begin
        for (int k = 0; k < lanes; k++) begin
            col_coef[k] = acc[k];
        end
    end

    // ==================================================
    // row count and block flag
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt   <= 2'd0;
            blk_valid <= 1'b0;
        end else begin
            if (row_fire) begin
                row_cnt <= row_cnt + 2'd1;
            end
            if (row_fire && row_cnt == 2'd3) begin
                blk_valid <= 1'b1;
            end else if (blk_ready) begin
                blk_valid <= 1'b0;
            end
        end
    end

    // ==================================================
    // accumulators
    // ==================================================
    // pattern k subtracts row r when k & r has odd parity,
    // which gives ++++, +-+-, ++--, +--+
    always_ff @(posedge clk) begin
        if (row_fire) begin
            for (int k = 0; k < lanes; k++) begin
                if (row_cnt == 2'd0) begin
                    acc[k] <= coef_ext;
                end else if (^(k[1:0] & row_cnt)) begin
                    acc[k] <= acc[k] - coef_ext;
                end else begin
                    acc[k] <= acc[k] + coef_ext;
                end
            end
        end
    end

    // a waiting block stays intact and the next block has not begun
    assert property (@(posedge clk) disable iff (!rst_n)
        blk_valid && !blk_ready |=> $stable(col_coef) && row_cnt == 2'd0);

endmodule

`default_nettype wire

// File: hdl/best_candidate.sv
/*
 * Drain stage: SATD of each finished block and the running minimum
 * over one search. Publishes the winning index and SATD on out_valid.
 */
`timescale 1ns/1ps
`default_nettype none

module best_candidate #(
    parameter int num_candidates = search_pkg::num_candidates_default
) (
    input  logic                                                      clk,
    input  logic                                                      rst_n,
    input  logic [satd_pkg::lanes-1:0]                                blk_valid,
    output logic                                                      blk_ready,
    input  satd_pkg::col_coef_t [satd_pkg::lanes*satd_pkg::lanes-1:0] blk_coef,
    output logic                                                      out_valid,
    input  logic                                                      out_ready,
    output search_pkg::cand_idx_t                                     best_idx,
    output satd_pkg::satd_t                                           best_satd
);
    import satd_pkg::*;
    import search_pkg::*;

    localparam cand_idx_t last_idx = cand_idx_t'(num_candidates - 1);

    logic      blk_fire;
    logic      last_cand;
    logic      take_new;
    satd_t     blk_satd;
    satd_t     min_satd;
    cand_idx_t min_idx;
    cand_idx_t cand_cnt;

    // ==================================================
    // block SATD
    // ==================================================
    always_comb begin
        col_coef_t             c;
        logic [col_coef_w-1:0] mag;
        blk_satd = '0;
        for (int i = 0; i < lanes * lanes; i++) begin
            c        = blk_coef[i];
            mag      = (c < 0) ? -c : c;
            blk_satd = blk_satd + {{(satd_w - col_coef_w){1'b0}}, mag};
        end
    end

    // ==================================================
    // search control
    // ==================================================
    assign blk_ready = !out_valid || out_ready;
    assign blk_fire  = (&blk_valid) && blk_ready;
    assign last_cand = (cand_cnt == last_idx);
    // strict compare keeps the earlier one on a tie
    assign take_new  = (cand_cnt == '0) || (blk_satd < min_satd);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cand_cnt  <= '0;
            out_valid <= 1'b0;
        end else begin
            if (blk_fire) begin
                cand_cnt <= last_cand ? '0 : cand_cnt + cand_idx_t'(1);
            end
            if (blk_fire && last_cand) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (blk_fire && take_new) begin
            min_satd <= blk_satd;
            min_idx  <= cand_cnt;
        end
        // result register, includes the last candidate itself
        if (blk_fire && last_cand) begin
            best_idx  <= take_new ? cand_cnt : min_idx;
            best_satd <= take_new ? blk_satd : min_satd;
        end
    end

    // all column units finish a block on the same cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        (|blk_valid) |-> (&blk_valid));

    assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(best_idx) && $stable(best_satd));

endmodule

`default_nettype wire

// File: hdl/mvdm_top.sv
/*
 * Top of the bi-prediction refinement search core. Rows of L0/L1
 * pixels go in, the best candidate index and its SATD come out.
 */
`timescale 1ns/1ps
`default_nettype none

module mvdm_top #(
    parameter int num_candidates = search_pkg::num_candidates_default
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     in_valid,
    output logic                                     in_ready,
    input  satd_pkg::pixel_t [satd_pkg::lanes-1:0]   in_l0,
    input  satd_pkg::pixel_t [satd_pkg::lanes-1:0]   in_l1,
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output search_pkg::cand_idx_t                    best_idx,
    output satd_pkg::satd_t                          best_satd
);
    import satd_pkg::*;

    logic                        row_valid;
    logic                        row_ready;
    row_coef_t [lanes-1:0]       row_coef;
    logic [lanes-1:0]            col_ready;
    logic [lanes-1:0]            blk_valid;
    logic                        blk_ready;
    // column c owns entries c*lanes .. c*lanes+lanes-1
    col_coef_t [lanes*lanes-1:0] blk_coef;

    // ==================================================
    // horizontal stage
    // ==================================================
    row_transform u_row (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_l0     (in_l0),
        .in_l1     (in_l1),
        .row_valid (row_valid),
        .row_ready (row_ready),
        .row_coef  (row_coef)
    );

    // a row moves only when every column can take it
    assign row_ready = &col_ready;

    // ==================================================
    // vertical stage, one unit per column
    // ==================================================
    for (genvar c = 0; c < lanes; c++) begin : g_col
        column_accum u_col (
            .clk       (clk),
            .rst_n     (rst_n),
            .row_valid (row_valid),
            .row_ready (col_ready[c]),
            .coef_in   (row_coef[c]),
            .blk_valid (blk_valid[c]),
            .blk_ready (blk_ready),
            .col_coef  (blk_coef[c*lanes +: lanes])
        );
    end

    // ==================================================
    // drain
    // ==================================================
    best_candidate #(
        .num_candidates (num_candidates)
    ) u_best (
        .clk       (clk),
        .rst_n     (rst_n),
        .blk_valid (blk_valid),
        .blk_ready (blk_ready),
        .blk_coef  (blk_coef),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .best_idx  (best_idx),
        .best_satd (best_satd)
    );

endmodule

`default_nettype wire

// File: tb/tb_mvdm.sv
/*
 * Testbench for the refinement search core. Reads tb/satd_tests.txt,
 * feeds nine candidate blocks per test with random input gaps and
 * output stalls, and checks the winning index and SATD of each test.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_mvdm;
    import satd_pkg::*;
    import search_pkg::*;

    localparam int rows_per_test   = 4 * num_candidates_default;
    localparam int reset_cycles    = 10;
    localparam int cycles_per_test = 200;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    logic               in_ready;
    pixel_t [lanes-1:0] in_l0;
    pixel_t [lanes-1:0] in_l1;
    logic               out_valid;
    logic               out_ready;
    cand_idx_t          best_idx;
    satd_t              best_satd;

    // test table, rows stored in file order
    string       names[$];
    logic [31:0] l0_rows[$];
    logic [31:0] l1_rows[$];
    int          exp_idx[$];
    int          exp_satd[$];

    int error_count   = 0;
    int timeout_count = 0;
    int cycle_count   = 0;
    int cycle_limit   = 0;

    mvdm_top #(
        .num_candidates (num_candidates_default)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_l0     (in_l0),
        .in_l1     (in_l1),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .best_idx  (best_idx),
        .best_satd (best_satd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==================================================
    // helpers
    // ==================================================
    task automatic check_value(input string test, input string what,
                               input int expected, input int actual);
        if (expected !== actual) begin
            error_count++;
            $display("** Error: test %s, %s: expected %0d, actual %0d",
                     test, what, expected, actual);
        end
    endtask

    // next line that is neither a comment nor empty
    task automatic read_data_line(input int fd, output string line, output bit ok);
        int n;
        ok = 1'b0;
        while (!ok && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        int          ei;
        int          es;
        bit          ok;
        string       line;
        string       name;
        logic [31:0] w [8];
        fd = $fopen("tb/satd_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file tb/satd_tests.txt");
            error_count++;
            return;
        end
        forever begin
            read_data_line(fd, line, ok);
            if (!ok) begin
                break;
            end
            n = $sscanf(line, "%s", name);
            names.push_back(name);
            for (int b = 0; b < num_candidates_default; b++) begin
                read_data_line(fd, line, ok);
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
                if (!ok || n != 8) begin
                    $display("test %s: block line %0d is missing or malformed", name, b);
                    error_count++;
                end
                for (int r = 0; r < 4; r++) begin
                    l0_rows.push_back(w[2*r]);
                    l1_rows.push_back(w[2*r+1]);
                end
            end
            read_data_line(fd, line, ok);
            n = $sscanf(line, "%d %d", ei, es);
            if (!ok || n != 2) begin
                $display("test %s: expected result line is missing or malformed", name);
                error_count++;
            end
            exp_idx.push_back(ei);
            exp_satd.push_back(es);
        end
        $fclose(fd);
    endtask

    // ==================================================
    // stimulus and response
    // ==================================================
    task automatic drive_test(input int t);
        int base;
        int gap;
        base = t * rows_per_test;
        for (int r = 0; r < rows_per_test; r++) begin
            gap = $urandom % 3;
            repeat (gap) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
            @(negedge clk);
            in_valid = 1'b1;
            in_l0    = l0_rows[base + r];
            in_l1    = l1_rows[base + r];
            // in_ready is settled shortly after the falling edge
            #1;
            while (!in_ready) begin
                @(negedge clk);
                #1;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic collect_result(input int t);
        bit        done;
        bit        held;
        int        stall;
        cand_idx_t held_idx;
        satd_t     held_satd;
        done  = 1'b0;
        held  = 1'b0;
        // hold the result long enough for the next search to back up
        stall = 16 + ($urandom % 16);
        while (!done) begin
            @(negedge clk);
            if (out_valid && stall > 0) begin
                out_ready = 1'b0;
                stall--;
            end else begin
                out_ready = ($urandom % 4) != 0;
            end
            #1;
            // a stalled result must not move
            if (held) begin
                if (!out_valid) begin
                    $display("test %s: out_valid fell before the result was taken", names[t]);
                    error_count++;
                end
                check_value(names[t], "held best_idx", int'(held_idx), int'(best_idx));
                check_value(names[t], "held best_satd", int'(held_satd), int'(best_satd));
            end
            held      = out_valid && !out_ready;
            held_idx  = best_idx;
            held_satd = best_satd;
            if (out_valid && out_ready) begin
                check_value(names[t], "best_idx", exp_idx[t], int'(best_idx));
                check_value(names[t], "best_satd", exp_satd[t], int'(best_satd));
                done = 1'b1;
            end
        end
    endtask

    task automatic finish_run();
        $display("tests: %0d, errors: %0d, timeouts: %0d",
                 names.size(), error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0 && names.size() > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        void'($urandom(32'h91f0_d07a));
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_l0     = '0;
        in_l1     = '0;
        out_ready = 1'b0;
        load_tests();
        cycle_limit = cycles_per_test * names.size() + reset_cycles;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_value("reset", "out_valid", 0, int'(out_valid));
        check_value("reset", "in_ready", 1, int'(in_ready));
        // tests run back to back without a reset in between,
        // so the next search backs up behind a stalled result
        fork
            begin
                for (int t = 0; t < names.size(); t++) begin
                    drive_test(t);
                end
            end
            begin
                for (int t = 0; t < names.size(); t++) begin
                    collect_result(t);
                end
            end
        join
        repeat (2) @(negedge clk);
        finish_run();
    end

    // watchdog
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        timeout_count++;
        $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
        finish_run();
    end

endmodule

`default_nettype wire

// File: files.f
hdl/satd_pkg.sv
hdl/search_pkg.sv
hdl/row_transform.sv
hdl/column_accum.sv
hdl/best_candidate.sv
hdl/mvdm_top.sv
tb/tb_mvdm.sv

// File: Makefile
# Verilator build and run of the refinement search core testbench

VERILATOR ?= verilator
TOP       ?= tb_mvdm
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_TEXT ?= Verification passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_TEXT)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: tb/satd_tests.txt
# per test: a name line, nine block lines, then the expected index and SATD in decimal
# block line: row0 l0 l1 row1 l0 l1 row2 l0 l1 row3 l0 l1, byte 0 of each word is lane 0
all_equal
01020304 01020304 10203040 10203040 ff00ff00 ff00ff00 7f7f7f7f 7f7f7f7f
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
ffffffff ffffffff 80808080 80808080 01010101 01010101 a5a5a5a5 a5a5a5a5
12345678 12345678 9abcdef0 9abcdef0 0f1e2d3c 0f1e2d3c 4b5a6978 4b5a6978
33333333 33333333 cccccccc cccccccc 55555555 55555555 aaaaaaaa aaaaaaaa
00ff00ff 00ff00ff ff00ff00 ff00ff00 00ff00ff 00ff00ff ff00ff00 ff00ff00
20406080 20406080 a0c0e0ff a0c0e0ff 08090a0b 08090a0b 0c0d0e0f 0c0d0e0f
deadbeef deadbeef 0badf00d 0badf00d 11223344 11223344 55667788 55667788
7e7e7e7e 7e7e7e7e 81818181 81818181 3c3c3c3c 3c3c3c3c c3c3c3c3 c3c3c3c3
0 0

single_pixel
50505050 46464646 50505050 46464646 50505050 46464646 50505050 46464646
a0a0a0a0 a9a9a9a9 a0a0a0a0 a9a9a9a9 a0a0a0a0 a9a9a9a9 a0a0a0a0 a9a9a9a9
50515253 48494a4b 50515253 48494a4b 50515253 48494a4b 50515253 48494a4b
50505050 3c3c3c3c 50505050 3c3c3c3c 50505050 3c3c3c3c 50505050 3c3c3c3c
50505050 58585858 50505050 58585858 50505050 58585858 50505050 58585858
80808080 80808080 80808080 80808080 80808080 80808780 80808080 80808080
50505050 44444444 50505050 44444444 50505050 44444444 50505050 44444444
50505050 6e6e6e6e 50505050 6e6e6e6e 50505050 6e6e6e6e 50505050 6e6e6e6e
50505050 48484848 50505050 48484848 50505050 48484848 50505050 48484848
5 112

uniform_tie
30313233 2b2c2d2e 30313233 2b2c2d2e 30313233 2b2c2d2e 30313233 2b2c2d2e
30303030 36363636 30303030 36363636 30303030 36363636 30303030 36363636
ffffffff 00000000 ffffffff 00000000 ffffffff 00000000 ffffffff 00000000
10101010 13131313 40414243 43444546 f0f0f0f0 f3f3f3f3 00010203 03040506
64656667 60616263 64656667 60616263 64656667 60616263 64656667 60616263
64646464 5d5d5d5d 64646464 5d5d5d5d 64646464 5d5d5d5d 64646464 5d5d5d5d
13131313 10101010 13131313 10101010 13131313 10101010 13131313 10101010
20212223 23242526 20212223 23242526 20212223 23242526 20212223 23242526
00000000 ffffffff 00000000 ffffffff 00000000 ffffffff 00000000 ffffffff
3 48
